// ==== alu.sv ====
`include "exec_consts.svh"

module alu import exec_pkg::*; (
    input  xlen_t     rs1_data_i,
    input  xlen_t     rs2_data_i,
    input  xlen_t     pc_i,
    dec_if.alu_mp     ctl,
    output xlen_t     alu_result_o
);

    xlen_t                   op_a;
    xlen_t                   op_b;
    logic [`EXEC_SHAMT_W-1:0] shamt;
    xlen_t                   sra_res;
    logic                    lt_signed;
    logic                    lt_unsigned;

    // pc as operand a only for auipc
    assign op_a = ctl.op_a_is_pc ? pc_i : rs1_data_i;
    assign op_b = ctl.op_b_is_imm ? ctl.imm : rs2_data_i;

    // upper operand bits are ignored for shifts
    assign shamt = op_b[`EXEC_SHAMT_W-1:0];

    // arithmetic shift needs a signed left operand
    assign sra_res = $signed(op_a) >>> shamt;

    assign lt_signed   = $signed(op_a) < $signed(op_b);
    assign lt_unsigned = op_a < op_b;

    always_comb begin
        case (ctl.alu_op)
            ALU_ADD:    alu_result_o = op_a + op_b;
            ALU_SUB:    alu_result_o = op_a - op_b;
            ALU_XOR:    alu_result_o = op_a ^ op_b;
            ALU_OR:     alu_result_o = op_a | op_b;
            ALU_AND:    alu_result_o = op_a & op_b;
            ALU_SLL:    alu_result_o = op_a << shamt;
            ALU_SRL:    alu_result_o = op_a >> shamt;
            ALU_SRA:    alu_result_o = sra_res;
            // compares give 0 or 1 in the low bit
            ALU_SLT:    alu_result_o = {{(`EXEC_XLEN-1){1'b0}}, lt_signed};
            ALU_SLTU:   alu_result_o = {{(`EXEC_XLEN-1){1'b0}}, lt_unsigned};
            ALU_PASS_B: alu_result_o = op_b;
            default:    alu_result_o = '0;
        endcase
    end

endmodule

// ==== branch_unit.sv ====
`include "exec_consts.svh"

module branch_unit import exec_pkg::*; (
    input  xlen_t     rs1_data_i,
    input  xlen_t     rs2_data_i,
    input  xlen_t     pc_i,
    dec_if.br_mp      ctl,
    output logic      taken_o,
    output xlen_t     target_o,
    output xlen_t     link_o
);

    logic  cond_met;
    xlen_t tgt_base;
    xlen_t tgt_sum;

    // compare always on the two register operands
    always_comb begin
        case (ctl.br_cond)
            BR_EQ:   cond_met = rs1_data_i == rs2_data_i;
            BR_NE:   cond_met = rs1_data_i != rs2_data_i;
            BR_LT:   cond_met = $signed(rs1_data_i) < $signed(rs2_data_i);
            BR_GE:   cond_met = $signed(rs1_data_i) >= $signed(rs2_data_i);
            BR_LTU:  cond_met = rs1_data_i < rs2_data_i;
            BR_GEU:  cond_met = rs1_data_i >= rs2_data_i;
            default: cond_met = 1'b0;
        endcase
    end

    // jumps are unconditional redirects
    assign taken_o = cond_met | ctl.is_jump;

    // jalr is register relative, everything else pc relative
    assign tgt_base = ctl.is_jalr ? rs1_data_i : pc_i;
    assign tgt_sum  = tgt_base + ctl.imm;

    // jalr drops bit 0 of the sum
    assign target_o = ctl.is_jalr ? {tgt_sum[`EXEC_XLEN-1:1], 1'b0} : tgt_sum;

    // return address for jal and jalr
    assign link_o = pc_i + xlen_t'(`EXEC_PC_STEP);

endmodule

// ==== dec_if.sv ====
interface dec_if import exec_pkg::*; ();

    // alu control and operand selects
    alu_op_e   alu_op;
    logic      op_a_is_pc;
    logic      op_b_is_imm;
    // sign-extended immediate of whatever format the opcode uses
    xlen_t     imm;
    // control flow
    br_cond_e  br_cond;
    logic      is_jump;
    logic      is_jalr;
    // writeback, wr_en already low for x0
    logic      wr_en;
    reg_addr_t rd;

    modport dec_mp (
        output alu_op, op_a_is_pc, op_b_is_imm, imm,
        output br_cond, is_jump, is_jalr, wr_en, rd
    );
    modport alu_mp (input alu_op, op_a_is_pc, op_b_is_imm, imm);
    modport br_mp  (input br_cond, imm, is_jump, is_jalr);
    modport out_mp (input wr_en, rd, is_jump);

endinterface

// ==== ex_out_reg.sv ====
module ex_out_reg import exec_pkg::*; (
    input  logic      i_clk,
    input  logic      reset_i,
    input  logic      en_i,
    input  xlen_t     alu_result_i,
    input  xlen_t     link_i,
    input  logic      taken_i,
    input  xlen_t     target_i,
    dec_if.out_mp     ctl,
    output logic      valid_o,
    output xlen_t     result_o,
    output xlen_t     target_o,
    output logic      branch_taken_o,
    output logic      jump_o,
    output logic      wr_en_o,
    output reg_addr_t rd_o
);

    xlen_t result_sel;

    // jumps write the link value, everything else the alu result
    assign result_sel = ctl.is_jump ? link_i : alu_result_i;

    always_ff @(posedge i_clk) begin
        if (reset_i) begin
            valid_o        <= 1'b0;
            branch_taken_o <= 1'b0;
            jump_o         <= 1'b0;
            wr_en_o        <= 1'b0;
            result_o       <= '0;
            target_o       <= '0;
            rd_o           <= '0;
        end else begin
            // flags only live for one cycle after an enabled slot
            valid_o        <= en_i;
            branch_taken_o <= en_i & taken_i;
            jump_o         <= en_i & ctl.is_jump;
            wr_en_o        <= en_i & ctl.wr_en;
            // data holds its last value across idle slots
            if (en_i) begin
                result_o <= result_sel;
                target_o <= target_i;
                rd_o     <= ctl.rd;
            end
        end
    end

endmodule

// ==== exec_consts.svh ====
`ifndef EXEC_CONSTS_SVH
`define EXEC_CONSTS_SVH

// datapath and register file geometry
`define EXEC_XLEN     32
`define EXEC_REG_AW   5
// link value is the address of the next sequential instruction
`define EXEC_PC_STEP  4
// only the low bits of operand b feed the shifter
`define EXEC_SHAMT_W  5

// major opcodes, instr[6:0]
`define EXEC_OPC_OP      7'b0110011
`define EXEC_OPC_OP_IMM  7'b0010011
`define EXEC_OPC_LOAD    7'b0000011
`define EXEC_OPC_STORE   7'b0100011
`define EXEC_OPC_BRANCH  7'b1100011
`define EXEC_OPC_JAL     7'b1101111
`define EXEC_OPC_JALR    7'b1100111
`define EXEC_OPC_LUI     7'b0110111
`define EXEC_OPC_AUIPC   7'b0010111

`endif

// ==== exec_pkg.sv ====
`include "exec_consts.svh"

package exec_pkg;

    typedef logic [`EXEC_XLEN-1:0]   xlen_t;
    typedef logic [`EXEC_REG_AW-1:0] reg_addr_t;

    // internal alu micro-ops, independent of the isa encoding
    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_XOR,
        ALU_OR,
        ALU_AND,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_SLT,
        ALU_SLTU,
        // lui passes the u immediate straight through
        ALU_PASS_B
    } alu_op_e;

    // branch compare, none for every non-branch instruction
    typedef enum logic [2:0] {
        BR_NONE,
        BR_EQ,
        BR_NE,
        BR_LT,
        BR_GE,
        BR_LTU,
        BR_GEU
    } br_cond_e;

endpackage

// ==== exec_stage.f ====
+incdir+.
rv_isa_pkg.sv
exec_pkg.sv
dec_if.sv
instr_decoder.sv
alu.sv
branch_unit.sv
ex_out_reg.sv
exec_stage.sv
tb_exec_stage.sv

// ==== exec_stage.sv ====
module exec_stage import exec_pkg::*; (
    input  logic      i_clk,
    input  logic      reset_i,
    input  logic      en_i,
    input  xlen_t     instr_i,
    input  xlen_t     rs1_data_i,
    input  xlen_t     rs2_data_i,
    input  xlen_t     pc_i,
    output logic      valid_o,
    output xlen_t     result_o,
    output xlen_t     target_o,
    output logic      branch_taken_o,
    output logic      jump_o,
    output logic      wr_en_o,
    output reg_addr_t rd_o
);

    // decoded control, shared by the alu, branch unit and output register
    dec_if dec_bus ();

    xlen_t alu_result;
    xlen_t br_target;
    xlen_t link_val;
    logic  br_taken;

    instr_decoder u_dec (
        .instr_i (instr_i),
        .dec     (dec_bus)
    );

    alu u_alu (
        .rs1_data_i   (rs1_data_i),
        .rs2_data_i   (rs2_data_i),
        .pc_i         (pc_i),
        .ctl          (dec_bus),
        .alu_result_o (alu_result)
    );

    branch_unit u_br (
        .rs1_data_i (rs1_data_i),
        .rs2_data_i (rs2_data_i),
        .pc_i       (pc_i),
        .ctl        (dec_bus),
        .taken_o    (br_taken),
        .target_o   (br_target),
        .link_o     (link_val)
    );

    // single register stage, one cycle of latency
    ex_out_reg u_out (
        .i_clk          (i_clk),
        .reset_i        (reset_i),
        .en_i           (en_i),
        .alu_result_i   (alu_result),
        .link_i         (link_val),
        .taken_i        (br_taken),
        .target_i       (br_target),
        .ctl            (dec_bus),
        .valid_o        (valid_o),
        .result_o       (result_o),
        .target_o       (target_o),
        .branch_taken_o (branch_taken_o),
        .jump_o         (jump_o),
        .wr_en_o        (wr_en_o),
        .rd_o           (rd_o)
    );

endmodule

// ==== exec_stimulus.txt ====
# name instr rs1 rs2 pc result target taken jump wr_en rd chk
# chk selects checked fields, bit0 result bit1 target bit2 rd
add      002081b3 7fffffff 00000001 00000000 80000000 00000000 0 0 1 03 5
sub      402081b3 00000005 00000007 00000000 fffffffe 00000000 0 0 1 03 5
xor      0020c1b3 f0f0f0f0 ff00ff00 00000000 0ff00ff0 00000000 0 0 1 03 5
or       0020e1b3 f0f0f0f0 0f0f0000 00000000 fffff0f0 00000000 0 0 1 03 5
and      0020f1b3 f0f0f0f0 ff00ff00 00000000 f000f000 00000000 0 0 1 03 5
sll      002091b3 00000001 00000024 00000000 00000010 00000000 0 0 1 03 5
srl      0020d1b3 80000000 0000001f 00000000 00000001 00000000 0 0 1 03 5
sra      4020d1b3 80000000 00000004 00000000 f8000000 00000000 0 0 1 03 5
slt      0020a1b3 ffffffff 00000001 00000000 00000001 00000000 0 0 1 03 5
sltu     0020b1b3 ffffffff 00000001 00000000 00000000 00000000 0 0 1 03 5
add_x0   00208033 00000001 00000002 00000000 00000003 00000000 0 0 0 00 1
addi     fff08193 00000010 00000000 00000000 0000000f 00000000 0 0 1 03 5
slti     fff0a193 00000005 00000000 00000000 00000000 00000000 0 0 1 03 5
sltiu    fff0b193 00000005 00000000 00000000 00000001 00000000 0 0 1 03 5
xori     0ff0c193 12345678 00000000 00000000 12345687 00000000 0 0 1 03 5
ori      7000e193 00000011 00000000 00000000 00000711 00000000 0 0 1 03 5
andi     ff00f193 12345678 00000000 00000000 12345670 00000000 0 0 1 03 5
slli     00809193 000000ab 00000000 00000000 0000ab00 00000000 0 0 1 03 5
srli     0040d193 f0000000 00000000 00000000 0f000000 00000000 0 0 1 03 5
srai     4040d193 f0000000 00000000 00000000 ff000000 00000000 0 0 1 03 5
lui      123452b7 00000000 00000000 00000000 12345000 00000000 0 0 1 05 5
auipc    00001297 00000000 00000000 00000100 00001100 00000000 0 0 1 05 5
beq_t    00208863 00000005 00000005 00000200 00000000 00000210 1 0 0 00 2
beq_n    fe208ce3 00000005 00000006 00000200 00000000 000001f8 0 0 0 00 2
bne_t    fe209ce3 00000005 00000006 00000200 00000000 000001f8 1 0 0 00 2
bne_n    00209863 00000005 00000005 00000200 00000000 00000210 0 0 0 00 2
blt_t    0020c863 ffffffff 00000001 00000200 00000000 00000210 1 0 0 00 2
blt_n    0020c863 00000001 ffffffff 00000200 00000000 00000210 0 0 0 00 2
bge_t    0020d863 00000001 ffffffff 00000200 00000000 00000210 1 0 0 00 2
bge_n    0020d863 ffffffff 00000001 00000200 00000000 00000210 0 0 0 00 2
bltu_t   0020e863 00000001 ffffffff 00000200 00000000 00000210 1 0 0 00 2
bltu_n   0020e863 ffffffff 00000001 00000200 00000000 00000210 0 0 0 00 2
bgeu_t   0020f863 ffffffff 00000001 00000200 00000000 00000210 1 0 0 00 2
bgeu_n   0020f863 00000001 ffffffff 00000200 00000000 00000210 0 0 0 00 2
jal      100000ef 00000000 00000000 00001000 00001004 00001100 1 1 1 01 7
jal_x0   ffdff06f 00000000 00000000 00002000 00002004 00001ffc 1 1 0 00 3
jalr     003100e7 00003000 00000000 00000400 00000404 00003002 1 1 1 01 7
lw       ffc0a183 00001000 00000000 00000000 00000ffc 00000000 0 0 1 03 5
sw       0020a423 00002000 0000abcd 00000000 00002008 00000000 0 0 0 00 1
sw_neg   fe20aa23 00002000 0000abcd 00000000 00001ff4 00000000 0 0 0 00 1
csrrw    300091f3 00000001 00000002 00000300 00000000 00000000 0 0 0 00 0
fence    0ff0000f 00000000 00000000 00000000 00000000 00000000 0 0 0 00 0

// ==== instr_decoder.sv ====
`include "exec_consts.svh"

module instr_decoder import rv_isa_pkg::*; import exec_pkg::*; (
    input  rv_instr_u instr_i,
    dec_if.dec_mp     dec
);

    xlen_t imm_i;
    xlen_t imm_s;
    xlen_t imm_b;
    xlen_t imm_u;
    xlen_t imm_j;
    logic  wr_req;

    // funct3 plus instr[30] to micro-op, sub only exists in the register form
    function automatic alu_op_e alu_op_of(rv_funct3_e f3, logic alt, logic reg_form);
        alu_op_e op;
        case (f3)
            F3_ADD_SUB: op = (alt && reg_form) ? ALU_SUB : ALU_ADD;
            F3_SLL:     op = ALU_SLL;
            F3_SLT:     op = ALU_SLT;
            F3_SLTU:    op = ALU_SLTU;
            F3_XOR:     op = ALU_XOR;
            F3_SR:      op = alt ? ALU_SRA : ALU_SRL;
            F3_OR:      op = ALU_OR;
            default:    op = ALU_AND;
        endcase
        return op;
    endfunction

    // funct3 values 2 and 3 are reserved in the branch group
    function automatic br_cond_e br_cond_of(rv_funct3_e f3);
        br_cond_e cond;
        case (f3)
            F3_BEQ:  cond = BR_EQ;
            F3_BNE:  cond = BR_NE;
            F3_BLT:  cond = BR_LT;
            F3_BGE:  cond = BR_GE;
            F3_BLTU: cond = BR_LTU;
            F3_BGEU: cond = BR_GEU;
            default: cond = BR_NONE;
        endcase
        return cond;
    endfunction

    // immediates per format, all sign-extended from instr[31]
    assign imm_i = {{(`EXEC_XLEN-12){instr_i.i_fmt.imm[11]}}, instr_i.i_fmt.imm};
    assign imm_s = {{(`EXEC_XLEN-12){instr_i.s_fmt.imm_hi[6]}},
                    instr_i.s_fmt.imm_hi, instr_i.s_fmt.imm_lo};
    assign imm_b = {{(`EXEC_XLEN-13){instr_i.b_fmt.imm_12}}, instr_i.b_fmt.imm_12,
                    instr_i.b_fmt.imm_11, instr_i.b_fmt.imm_10_5,
                    instr_i.b_fmt.imm_4_1, 1'b0};
    // u immediate already fills the upper bits
    assign imm_u = {instr_i.u_fmt.imm_31_12, 12'b0};
    assign imm_j = {{(`EXEC_XLEN-21){instr_i.j_fmt.imm_20}}, instr_i.j_fmt.imm_20,
                    instr_i.j_fmt.imm_19_12, instr_i.j_fmt.imm_11,
                    instr_i.j_fmt.imm_10_1, 1'b0};

    always_comb begin
        // defaults describe an unknown opcode
        dec.alu_op      = ALU_ADD;
        dec.op_a_is_pc  = 1'b0;
        dec.op_b_is_imm = 1'b0;
        dec.imm         = '0;
        dec.br_cond     = BR_NONE;
        dec.is_jump     = 1'b0;
        dec.is_jalr     = 1'b0;
        wr_req          = 1'b0;
        case (instr_i.r_fmt.opcode)
            OPC_OP: begin
                dec.alu_op = alu_op_of(instr_i.r_fmt.funct3, instr_i.r_fmt.funct7[5], 1'b1);
                wr_req     = 1'b1;
            end
            OPC_OP_IMM: begin
                // shift immediates carry the sra select in instr[30] too
                dec.alu_op      = alu_op_of(instr_i.i_fmt.funct3,
                                            instr_i.r_fmt.funct7[5], 1'b0);
                dec.op_b_is_imm = 1'b1;
                dec.imm         = imm_i;
                wr_req          = 1'b1;
            end
            OPC_LOAD: begin
                dec.op_b_is_imm = 1'b1;
                dec.imm         = imm_i;
                wr_req          = 1'b1;
            end
            OPC_STORE: begin
                dec.op_b_is_imm = 1'b1;
                dec.imm         = imm_s;
            end
            OPC_BRANCH: begin
                dec.br_cond = br_cond_of(instr_i.b_fmt.funct3);
                dec.imm     = imm_b;
            end
            OPC_JAL: begin
                dec.imm     = imm_j;
                dec.is_jump = 1'b1;
                wr_req      = 1'b1;
            end
            OPC_JALR: begin
                dec.imm     = imm_i;
                dec.is_jump = 1'b1;
                dec.is_jalr = 1'b1;
                wr_req      = 1'b1;
            end
            OPC_LUI: begin
                dec.alu_op      = ALU_PASS_B;
                dec.op_b_is_imm = 1'b1;
                dec.imm         = imm_u;
                wr_req          = 1'b1;
            end
            OPC_AUIPC: begin
                dec.op_a_is_pc  = 1'b1;
                dec.op_b_is_imm = 1'b1;
                dec.imm         = imm_u;
                wr_req          = 1'b1;
            end
            default: begin
            end
        endcase
    end

    // rd sits at the same bits in every format that writes
    assign dec.rd    = instr_i.r_fmt.rd;
    // writes to x0 are dropped here
    assign dec.wr_en = wr_req && (instr_i.r_fmt.rd != '0);

endmodule

// ==== run_sim.sh ====
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f exec_stage.f --top-module tb_exec_stage -o sim_exec
sim_out=$(./obj_dir/sim_exec)
echo "$sim_out"

if echo "$sim_out" | grep -q "ALL TESTS PASSED"; then
    exit 0
else
    exit 1
fi

// ==== rv_isa_pkg.sv ====
`include "exec_consts.svh"

package rv_isa_pkg;

    // opcodes this stage executes, anything else decodes as unknown
    typedef enum logic [6:0] {
        OPC_OP     = `EXEC_OPC_OP,
        OPC_OP_IMM = `EXEC_OPC_OP_IMM,
        OPC_LOAD   = `EXEC_OPC_LOAD,
        OPC_STORE  = `EXEC_OPC_STORE,
        OPC_BRANCH = `EXEC_OPC_BRANCH,
        OPC_JAL    = `EXEC_OPC_JAL,
        OPC_JALR   = `EXEC_OPC_JALR,
        OPC_LUI    = `EXEC_OPC_LUI,
        OPC_AUIPC  = `EXEC_OPC_AUIPC
    } rv_opcode_e;

    // funct3 of the integer alu group
    typedef enum logic [2:0] {
        F3_ADD_SUB = 3'b000,
        F3_SLL     = 3'b001,
        F3_SLT     = 3'b010,
        F3_SLTU    = 3'b011,
        F3_XOR     = 3'b100,
        F3_SR      = 3'b101,
        F3_OR      = 3'b110,
        F3_AND     = 3'b111
    } rv_funct3_e;

    // branch group reuses the same encodings
    localparam rv_funct3_e F3_BEQ  = F3_ADD_SUB;
    localparam rv_funct3_e F3_BNE  = F3_SLL;
    localparam rv_funct3_e F3_BLT  = F3_XOR;
    localparam rv_funct3_e F3_BGE  = F3_SR;
    localparam rv_funct3_e F3_BLTU = F3_OR;
    localparam rv_funct3_e F3_BGEU = F3_AND;

    // one instruction word, one view per encoding format
    typedef union packed {
        struct packed {
            logic [6:0] funct7;
            logic [4:0] rs2;
            logic [4:0] rs1;
            rv_funct3_e funct3;
            logic [4:0] rd;
            rv_opcode_e opcode;
        } r_fmt;
        struct packed {
            logic [11:0] imm;
            logic [4:0]  rs1;
            rv_funct3_e  funct3;
            logic [4:0]  rd;
            rv_opcode_e  opcode;
        } i_fmt;
        struct packed {
            logic [6:0] imm_hi;
            logic [4:0] rs2;
            logic [4:0] rs1;
            rv_funct3_e funct3;
            logic [4:0] imm_lo;
            rv_opcode_e opcode;
        } s_fmt;
        struct packed {
            logic       imm_12;
            logic [5:0] imm_10_5;
            logic [4:0] rs2;
            logic [4:0] rs1;
            rv_funct3_e funct3;
            logic [3:0] imm_4_1;
            logic       imm_11;
            rv_opcode_e opcode;
        } b_fmt;
        struct packed {
            logic [19:0] imm_31_12;
            logic [4:0]  rd;
            rv_opcode_e  opcode;
        } u_fmt;
        struct packed {
            logic       imm_20;
            logic [9:0] imm_10_1;
            logic       imm_11;
            logic [7:0] imm_19_12;
            logic [4:0] rd;
            rv_opcode_e opcode;
        } j_fmt;
    } rv_instr_u;

endpackage

// ==== tb_exec_stage.sv ====
`include "exec_consts.svh"

module tb_exec_stage import exec_pkg::*; ();

    localparam int WAIT_LIMIT = 8;
    localparam int RAND_COUNT = 16;

    logic      clk;
    logic      reset;
    logic      en;
    xlen_t     instr;
    xlen_t     rs1;
    xlen_t     rs2;
    xlen_t     pc;
    logic      valid;
    xlen_t     result;
    xlen_t     target;
    logic      taken;
    logic      jump;
    logic      wr_en;
    reg_addr_t rd;

    int    n_pass;
    int    n_fail;
    bit    test_ok;
    xlen_t lcg_state;

    exec_stage DUT (
        .i_clk          (clk),
        .reset_i        (reset),
        .en_i           (en),
        .instr_i        (instr),
        .rs1_data_i     (rs1),
        .rs2_data_i     (rs2),
        .pc_i           (pc),
        .valid_o        (valid),
        .result_o       (result),
        .target_o       (target),
        .branch_taken_o (taken),
        .jump_o         (jump),
        .wr_en_o        (wr_en),
        .rd_o           (rd)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // numerical recipes constants
    function automatic xlen_t lcg_next(xlen_t s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic check_word(string tname, string field, xlen_t exp_v, xlen_t act_v);
        assert (act_v === exp_v) else begin
            $display("ERR %s %s expected %h actual %h", tname, field, exp_v, act_v);
            test_ok = 1'b0;
        end
    endtask

    task automatic end_test(string tname);
        if (test_ok) begin
            n_pass++;
            $display("PASS %s", tname);
        end else begin
            n_fail++;
            $display("FAIL %s", tname);
        end
        test_ok = 1'b1;
    endtask

    // called on a falling edge
    task automatic drive(xlen_t i_w, xlen_t a, xlen_t b, xlen_t p);
        en    = 1'b1;
        instr = i_w;
        rs1   = a;
        rs2   = b;
        pc    = p;
    endtask

    // one enabled slot, then idle until the result shows up
    task automatic run_vector(string tname, xlen_t i_w, xlen_t a, xlen_t b, xlen_t p,
                              xlen_t e_res, xlen_t e_tgt, logic e_tk, logic e_jp,
                              logic e_wr, logic [4:0] e_rd, logic [2:0] chk);
        int cyc;
        drive(i_w, a, b, p);
        @(negedge clk);
        en  = 1'b0;
        cyc = 1;
        while (!valid && cyc < WAIT_LIMIT) begin
            @(negedge clk);
            cyc++;
        end
        if (!valid) begin
            $display("test %s got no valid output within %0d cycles", tname, WAIT_LIMIT);
            test_ok = 1'b0;
        end else begin
            check_word(tname, "latency", 32'd1, xlen_t'(cyc));
            check_word(tname, "taken", {31'b0, e_tk}, {31'b0, taken});
            check_word(tname, "jump", {31'b0, e_jp}, {31'b0, jump});
            check_word(tname, "wr_en", {31'b0, e_wr}, {31'b0, wr_en});
            // chk masks fields with no defined value for this instruction
            if (chk[0])
                check_word(tname, "result", e_res, result);
            if (chk[1])
                check_word(tname, "target", e_tgt, target);
            if (chk[2])
                check_word(tname, "rd", {27'b0, e_rd}, {27'b0, rd});
        end
        end_test(tname);
    endtask

    initial begin
        int         cyc;
        int         fd;
        int         n;
        string      line;
        string      name;
        xlen_t      f_instr, f_rs1, f_rs2, f_pc, f_res, f_tgt;
        xlen_t      f_tk, f_jp, f_wr, f_rd, f_chk;
        xlen_t      a;
        xlen_t      b;
        xlen_t      sel;
        logic [4:0] r_rd;
        logic [2:0] f3;
        xlen_t      exp_q[$];
        reg_addr_t  rd_q[$];

        n_pass    = 0;
        n_fail    = 0;
        test_ok   = 1'b1;
        lcg_state = 32'h68501dd2;
        // a jal is offered during reset and must not come out
        reset = 1'b1;
        en    = 1'b1;
        instr = 32'h100000ef;
        rs1   = 32'h00000011;
        rs2   = 32'h00000022;
        pc    = 32'h00001000;

        cyc = 0;
        while (cyc < 5) begin
            @(negedge clk);
            cyc++;
        end
        // outputs still show the last reset edge
        check_word("reset_state", "valid", 32'd0, {31'b0, valid});
        check_word("reset_state", "wr_en", 32'd0, {31'b0, wr_en});
        check_word("reset_state", "taken", 32'd0, {31'b0, taken});
        check_word("reset_state", "jump", 32'd0, {31'b0, jump});
        check_word("reset_state", "result", 32'd0, result);
        check_word("reset_state", "target", 32'd0, target);
        check_word("reset_state", "rd", 32'd0, {27'b0, rd});
        end_test("reset_state");
        reset = 1'b0;
        en    = 1'b0;
        @(negedge clk);

        // directed vectors
        fd = $fopen("exec_stimulus.txt", "r");
        if (fd == 0) begin
            $display("cannot open exec_stimulus.txt for reading");
            n_fail++;
        end else begin
            while (!$feof(fd)) begin
                n = $fgets(line, fd);
                if (n > 0 && line.getc(0) != "#") begin
                    n = $sscanf(line, "%s %h %h %h %h %h %h %h %h %h %h %h", name,
                                f_instr, f_rs1, f_rs2, f_pc, f_res, f_tgt,
                                f_tk, f_jp, f_wr, f_rd, f_chk);
                    if (n == 12) begin
                        run_vector(name, f_instr, f_rs1, f_rs2, f_pc, f_res, f_tgt,
                                   f_tk[0], f_jp[0], f_wr[0], f_rd[4:0], f_chk[2:0]);
                    end else if (n > 0) begin
                        $display("malformed stimulus line %s", line);
                        n_fail++;
                    end
                end
            end
            $fclose(fd);
        end

        // addi x3 x1 1, then another operand offered with en low
        drive(32'h00108193, 32'h00000041, 32'h0, 32'h0);
        @(negedge clk);
        en  = 1'b0;
        rs1 = 32'h00000100;
        check_word("en_gating", "valid", 32'd1, {31'b0, valid});
        check_word("en_gating", "result", 32'h00000042, result);
        @(negedge clk);
        check_word("en_gating", "valid", 32'd0, {31'b0, valid});
        check_word("en_gating", "wr_en", 32'd0, {31'b0, wr_en});
        // data outputs hold across the idle slot
        check_word("en_gating", "result", 32'h00000042, result);
        end_test("en_gating");

        // back to back add and xor, result of slot i-1 checked while slot i is driven
        for (int i = 0; i <= RAND_COUNT; i++) begin
            if (i > 0) begin
                check_word($sformatf("rand_%0d", i - 1), "valid", 32'd1, {31'b0, valid});
                check_word($sformatf("rand_%0d", i - 1), "result", exp_q.pop_front(), result);
                check_word($sformatf("rand_%0d", i - 1), "rd", {27'b0, rd_q.pop_front()},
                           {27'b0, rd});
                check_word($sformatf("rand_%0d", i - 1), "wr_en", 32'd1, {31'b0, wr_en});
                end_test($sformatf("rand_%0d", i - 1));
            end
            if (i < RAND_COUNT) begin
                lcg_state = lcg_next(lcg_state);
                a         = lcg_state;
                lcg_state = lcg_next(lcg_state);
                b         = lcg_state;
                lcg_state = lcg_next(lcg_state);
                sel       = lcg_state;
                // high lcg bits are the better distributed ones
                r_rd = (sel[24:20] == 5'd0) ? 5'd1 : sel[24:20];
                f3   = sel[16] ? 3'b100 : 3'b000;
                drive({7'b0000000, 5'd2, 5'd1, f3, r_rd, `EXEC_OPC_OP}, a, b, 32'h0);
                exp_q.push_back(sel[16] ? (a ^ b) : (a + b));
                rd_q.push_back(r_rd);
            end else begin
                en = 1'b0;
            end
            @(negedge clk);
        end

        $display("tests passed %0d failed %0d", n_pass, n_fail);
        if (n_fail == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule
